/* fbuf_pkg.sv */
package fbuf_pkg;

    // data word and marker bytes
    localparam int WORD_WIDTH = 64;
    localparam int ID_WIDTH = 8;
    localparam logic [ID_WIDTH-1:0] HEADER_ID = 8'hAA;
    localparam logic [ID_WIDTH-1:0] FOOTER_ID = 8'h55;

    // slot ring geometry, a frame must fit one slot including header and footer
    localparam int SLOT_WORDS = 16;
    localparam int NUM_SLOTS = 4;
    localparam int SLOT_AW = 2;
    localparam int WORD_AW = 4;

    // flat store addressed as {slot index, word offset}
    localparam int MEM_AW = SLOT_AW + WORD_AW;
    localparam int MEM_WORDS = NUM_SLOTS * SLOT_WORDS;

    // one keep bit per byte of the output word
    localparam int KEEP_WIDTH = WORD_WIDTH / 8;

    // header layout, frame_length counts payload words only
    typedef struct packed {
        logic [ID_WIDTH-1:0]                 id;
        logic [11:0]                         channel_id;
        logic [11:0]                         frame_length;
        logic [WORD_WIDTH-ID_WIDTH-25:0]     rest;
    } header_view_t;

    // footer layout, word_count as written by the front end
    typedef struct packed {
        logic [ID_WIDTH-1:0]                 id;
        logic [15:0]                         word_count;
        logic [WORD_WIDTH-ID_WIDTH-17:0]     rest;
    } footer_view_t;

    // one stream word, seen as a header on ingress and as a footer on egress
    typedef union packed {
        header_view_t hdr;
        footer_view_t ftr;
    } fbuf_word_u;

    // internal beat between decode, ring control and slot store
    typedef struct packed {
        fbuf_word_u data;
        logic       valid;
        logic       last;
    } stream_beat_t;

    // slot pointer, wrap bit tells full from empty when indices match
    typedef struct packed {
        logic               wrap;
        logic [SLOT_AW-1:0] index;
    } slot_ptr_t;

endpackage

/* frame_header_decode.sv */
module frame_header_decode (
    input  logic                   ACLK,
    input  logic                   rst,
    input  fbuf_pkg::fbuf_word_u   s_data,
    input  logic                   s_valid,
    output logic                   s_tready,
    output fbuf_pkg::stream_beat_t wr_beat,
    input  logic                   wr_ready,
    output logic                   frame_error
);
    import fbuf_pkg::*;

    logic active;
    logic in_frame;
    logic dropping;
    logic is_header;
    logic is_footer;
    logic too_long;
    logic forward;
    logic s_fire;
    logic hdr_seen;

    // both markers sit in the same top byte, so the header view covers both
    assign is_header = s_data.hdr.id == HEADER_ID;
    assign is_footer = s_data.hdr.id == FOOTER_ID;

    // header, payload and footer must all fit into one slot
    assign too_long = ({1'b0, s_data.hdr.frame_length} + 13'd2) > 13'(SLOT_WORDS);

    // words of an accepted frame, or a header that opens one
    assign forward = in_frame || (!dropping && is_header && !too_long);

    assign wr_beat.data = s_data;
    assign wr_beat.valid = s_valid && active && forward;
    assign wr_beat.last = in_frame && is_footer;

    // discarded words are swallowed without waiting on the ring
    assign s_tready = active && (forward ? wr_ready : 1'b1);
    assign s_fire = s_valid && s_tready;

    always_ff @(posedge ACLK) begin
        if (rst) begin
            active <= 1'b0;
            in_frame <= 1'b0;
            dropping <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            active <= 1'b1;
            if (s_fire) begin
                if (in_frame) begin
                    if (is_footer) begin
                        in_frame <= 1'b0;
                    end
                end else if (dropping) begin
                    if (is_footer) begin
                        dropping <= 1'b0;
                    end
                end else if (is_header) begin
                    if (too_long) begin
                        // oversize frame is thrown away up to its footer
                        dropping <= 1'b1;
                        frame_error <= 1'b1;
                    end else begin
                        in_frame <= 1'b1;
                    end
                end
            end
        end
    end

    // frame tracking as seen from the ring side of the beat stream
    always_ff @(posedge ACLK) begin
        if (rst) begin
            hdr_seen <= 1'b0;
        end else if (wr_beat.valid && wr_ready) begin
            hdr_seen <= !wr_beat.last;
        end
    end

    // every run of beats toward the ring opens with a header
    a_header_first: assert property (@(posedge ACLK) disable iff (rst)
        wr_beat.valid && !hdr_seen |-> wr_beat.data.hdr.id == HEADER_ID)
        else $error("decode forwarded a beat without a prior header");

endmodule

/* slot_ring_ctrl.sv */
module slot_ring_ctrl (
    input  logic                   ACLK,
    input  logic                   rst,
    input  fbuf_pkg::stream_beat_t wr_beat,
    output logic                   wr_ready,
    output logic                   wr_en,
    output logic [5:0]             wr_addr,
    output fbuf_pkg::fbuf_word_u   wr_data,
    output logic [1:0]             rd_slot,
    output logic                   rd_avail,
    input  logic                   slot_done
);
    import fbuf_pkg::*;

    slot_ptr_t          wr_ptr;
    slot_ptr_t          rd_ptr;
    logic [WORD_AW-1:0] wr_off;
    logic               commit;
    logic               full;
    logic               empty;
    logic               wr_fire;

    // same slot with opposite wrap means the writer lapped the reader
    assign full = (wr_ptr.index == rd_ptr.index) && (wr_ptr.wrap != rd_ptr.wrap);
    assign empty = wr_ptr == rd_ptr;

    // hold off ingress while the finished slot is being committed
    assign wr_ready = !full && !commit;
    assign wr_fire = wr_beat.valid && wr_ready;

    // every accepted beat goes straight into the slot store
    assign wr_en = wr_fire;
    assign wr_addr = {wr_ptr.index, wr_off};
    assign wr_data = wr_beat.data;

    assign rd_slot = rd_ptr.index;
    assign rd_avail = !empty;

    always_ff @(posedge ACLK) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            wr_off <= '0;
            commit <= 1'b0;
        end else begin
            commit <= wr_fire && wr_beat.last;

            if (wr_fire) begin
                if (wr_beat.last) begin
                    wr_off <= '0;
                end else begin
                    wr_off <= wr_off + 1'b1;
                end
            end

            // carry out of the index flips the wrap bit
            if (commit) begin
                wr_ptr <= slot_ptr_t'(wr_ptr + 1'b1);
            end

            if (slot_done) begin
                rd_ptr <= slot_ptr_t'(rd_ptr + 1'b1);
            end
        end
    end

    // the last word position of a slot may only hold a footer,
    // which relies on the length check upstream
    a_offset_in_slot: assert property (@(posedge ACLK) disable iff (rst)
        wr_fire && wr_off == WORD_AW'(SLOT_WORDS - 1) |-> wr_beat.last)
        else $error("write offset ran past the end of the slot");

    // egress may only release a slot that was committed
    a_done_not_empty: assert property (@(posedge ACLK) disable iff (rst)
        slot_done |-> !empty)
        else $error("slot_done while the ring is empty");

endmodule

/* frame_slot_mem.sv */
module frame_slot_mem (
    input  logic                 ACLK,
    input  logic                 wr_en,
    input  logic [5:0]           wr_addr,
    input  fbuf_pkg::fbuf_word_u wr_data,
    input  logic [5:0]           rd_addr,
    input  logic                 rd_en,
    output fbuf_pkg::fbuf_word_u rd_word
);
    import fbuf_pkg::*;

    // all slots back to back, slot index in the upper address bits
    fbuf_word_u mem [MEM_WORDS];

    always_ff @(posedge ACLK) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, word shows up on the cycle after rd_en
    always_ff @(posedge ACLK) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

endmodule

/* frame_egress.sv */
module frame_egress (
    input  logic                 ACLK,
    input  logic                 rst,
    input  logic [1:0]           rd_slot,
    input  logic                 rd_avail,
    output logic                 slot_done,
    output logic [5:0]           rd_addr,
    output logic                 rd_en,
    input  fbuf_pkg::fbuf_word_u rd_word,
    output fbuf_pkg::fbuf_word_u m_data,
    output logic                 m_valid,
    output logic                 m_last,
    output logic [7:0]           m_keep,
    input  logic                 m_ready
);
    import fbuf_pkg::*;

    logic               busy;
    logic               eof_seen;
    logic [WORD_AW-1:0] rd_off;
    logic               pend;
    logic               hold_valid;
    logic               load;
    logic               ret_footer;
    logic               m_footer;

    // output register is free, or it empties on this edge
    assign load = !m_valid || m_ready;

    // word returned by the store this cycle is the footer
    assign ret_footer = pend && rd_word.ftr.id == FOOTER_ID;

    // only read when the returning word is sure to find room
    assign rd_en = busy && !eof_seen && !ret_footer && !hold_valid && !(pend && !load);
    assign rd_addr = {rd_slot, rd_off};

    assign m_footer = m_data.ftr.id == FOOTER_ID;
    assign m_last = m_valid && m_footer;
    // footer carries only its upper half
    assign m_keep = m_footer ? {{KEEP_WIDTH/2{1'b1}}, {KEEP_WIDTH/2{1'b0}}} : '1;

    assign slot_done = m_valid && m_ready && m_footer;

    always_ff @(posedge ACLK) begin
        if (rst) begin
            busy <= 1'b0;
            eof_seen <= 1'b0;
            rd_off <= '0;
            pend <= 1'b0;
            hold_valid <= 1'b0;
            m_valid <= 1'b0;
        end else begin
            pend <= rd_en;

            if (!busy && rd_avail) begin
                busy <= 1'b1;
                eof_seen <= 1'b0;
                rd_off <= '0;
            end else if (slot_done) begin
                busy <= 1'b0;
            end else begin
                if (rd_en) begin
                    rd_off <= rd_off + 1'b1;
                end
                if (ret_footer) begin
                    eof_seen <= 1'b1;
                end
            end

            // a returned word that finds the output full waits in the hold entry
            if (load) begin
                m_valid <= hold_valid || pend;
                hold_valid <= 1'b0;
            end else if (pend) begin
                hold_valid <= 1'b1;
            end
        end
    end

    // no read is issued while a word waits, so the store output register is the hold entry
    always_ff @(posedge ACLK) begin
        if (load) begin
            m_data <= rd_word;
        end
    end

    a_hold_stable: assert property (@(posedge ACLK) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_data))
        else $error("output word changed while stalled");

endmodule

/* frame_buffer_top.sv */
module frame_buffer_top (
    input  logic                 ACLK,
    input  logic                 rst,
    input  fbuf_pkg::fbuf_word_u s_data,
    input  logic                 s_valid,
    output logic                 s_tready,
    output fbuf_pkg::fbuf_word_u m_data,
    output logic                 m_valid,
    output logic                 m_last,
    output logic [7:0]           m_keep,
    input  logic                 m_ready,
    output logic                 frame_error
);
    import fbuf_pkg::*;

    stream_beat_t wr_beat;
    logic         wr_ready;
    logic         wr_en;
    logic [5:0]   wr_addr;
    fbuf_word_u   wr_data;
    logic [1:0]   rd_slot;
    logic         rd_avail;
    logic         slot_done;
    logic [5:0]   rd_addr;
    logic         rd_en;
    fbuf_word_u   rd_word;

    // decode stage
    frame_header_decode u_decode (
        .ACLK        (ACLK),
        .rst         (rst),
        .s_data      (s_data),
        .s_valid     (s_valid),
        .s_tready    (s_tready),
        .wr_beat     (wr_beat),
        .wr_ready    (wr_ready),
        .frame_error (frame_error)
    );

    // execute stage, ring pointers and slot store
    slot_ring_ctrl u_ring (
        .ACLK      (ACLK),
        .rst       (rst),
        .wr_beat   (wr_beat),
        .wr_ready  (wr_ready),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_slot   (rd_slot),
        .rd_avail  (rd_avail),
        .slot_done (slot_done)
    );

    frame_slot_mem u_mem (
        .ACLK    (ACLK),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_en   (rd_en),
        .rd_word (rd_word)
    );

    // result stage
    frame_egress u_egress (
        .ACLK      (ACLK),
        .rst       (rst),
        .rd_slot   (rd_slot),
        .rd_avail  (rd_avail),
        .slot_done (slot_done),
        .rd_addr   (rd_addr),
        .rd_en     (rd_en),
        .rd_word   (rd_word),
        .m_data    (m_data),
        .m_valid   (m_valid),
        .m_last    (m_last),
        .m_keep    (m_keep),
        .m_ready   (m_ready)
    );

endmodule

/* tb_frame_buffer.sv */
module tb_frame_buffer;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [7:0] HDR_BYTE = 8'hAA;
    localparam logic [7:0] FTR_BYTE = 8'h55;
    // about 256 words cross the buffer over all tests, 16 cycles per word is ample
    localparam int MAX_CYCLES = 256 * 16;
    localparam int RDY_HIGH = 0;
    localparam int RDY_LOW = 1;
    localparam int RDY_RAND = 2;

    logic        ACLK = 1'b0;
    logic        rst;
    logic [63:0] s_data;
    logic        s_valid;
    logic        s_tready;
    logic [63:0] m_data;
    logic        m_valid;
    logic        m_last;
    logic [7:0]  m_keep;
    logic        m_ready;
    logic        frame_error;

    int          seed = 32'h0142_ab71;
    // own stream for m_ready so payload values do not depend on the ready pattern
    int          ready_seed = 32'h0142_ab71;
    int          ready_mode = RDY_HIGH;
    int          cycle_count = 0;
    int          data_errors = 0;
    int          keep_errors = 0;
    int          last_errors = 0;
    int          hold_errors = 0;
    int          extra_errors = 0;
    int          ctrl_errors = 0;
    logic [63:0] exp_data [$];
    logic        exp_last [$];
    logic        stall_seen = 1'b0;
    logic [63:0] stall_data;

    frame_buffer_top UUT (
        .ACLK        (ACLK),
        .rst         (rst),
        .s_data      (s_data),
        .s_valid     (s_valid),
        .s_tready    (s_tready),
        .m_data      (m_data),
        .m_valid     (m_valid),
        .m_last      (m_last),
        .m_keep      (m_keep),
        .m_ready     (m_ready),
        .frame_error (frame_error)
    );

    always #20 ACLK = ~ACLK;

    initial begin
        int rnd;
        m_ready = 1'b0;
        forever begin
            @(posedge ACLK);
            rnd = $random(ready_seed);
            case (ready_mode)
                RDY_HIGH: m_ready <= 1'b1;
                RDY_LOW:  m_ready <= 1'b0;
                default:  m_ready <= rnd[0];
            endcase
        end
    end

    function automatic logic [63:0] make_header(input logic [11:0] ch, input logic [11:0] len);
        return {HDR_BYTE, ch, len, 20'h0_0000, ch};
    endfunction

    function automatic logic [63:0] make_footer(input logic [15:0] count);
        return {FTR_BYTE, count, 40'h12_3456_789a};
    endfunction

    function automatic logic [63:0] make_payload();
        logic [63:0] word;
        word = {$random(seed), $random(seed)};
        // payload must not carry a marker byte on top
        if (word[63:56] == HDR_BYTE || word[63:56] == FTR_BYTE) begin
            word[63:56] = word[63:56] ^ 8'h0F;
        end
        return word;
    endfunction

    task automatic print_counts();
        $display("error counts: data %0d, keep %0d, last %0d, hold %0d, extra %0d, ctrl %0d",
                 data_errors, keep_errors, last_errors, hold_errors, extra_errors, ctrl_errors);
    endtask

    always @(posedge ACLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            print_counts();
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_output();
        logic [63:0] want;
        logic        want_last;
        logic [7:0]  want_keep;
        logic [63:0] mask;
        assert (exp_data.size() != 0) else begin
            extra_errors++;
            $display("unexpected output word %h at %0t with no frame outstanding", m_data, $time);
        end
        if (exp_data.size() != 0) begin
            want = exp_data.pop_front();
            want_last = exp_last.pop_front();
            // a footer keeps its upper four bytes only
            want_keep = want_last ? 8'hF0 : 8'hFF;
            for (int i = 0; i < 8; i++) begin
                mask[i*8 +: 8] = {8{want_keep[i]}};
            end
            assert ((m_data & mask) == (want & mask)) else begin
                data_errors++;
                $display("FAILED %0t: data %h, expected %h", $time, m_data, want);
            end
            assert (m_keep == want_keep) else begin
                keep_errors++;
                $display("FAILED %0t: keep %h, expected %h", $time, m_keep, want_keep);
            end
            assert (m_last == want_last) else begin
                last_errors++;
                $display("FAILED %0t: last %b, expected %b", $time, m_last, want_last);
            end
        end
    endtask

    // output monitor, scoreboard compare and stall stability
    always @(posedge ACLK) begin
        if (!rst) begin
            if (stall_seen) begin
                assert (m_valid && m_data == stall_data) else begin
                    hold_errors++;
                    $display("FAILED %0t: held word %h changed to %h", $time, stall_data, m_data);
                end
            end
            if (m_valid && m_ready) begin
                check_output();
            end
            stall_seen = m_valid && !m_ready;
            stall_data = m_data;
        end
    end

    task automatic send_word(input logic [63:0] word);
        s_data <= word;
        s_valid <= 1'b1;
        @(posedge ACLK);
        while (!s_tready) begin
            @(posedge ACLK);
        end
    endtask

    task automatic stop_input();
        s_valid <= 1'b0;
    endtask

    task automatic expect_word(input logic [63:0] word, input logic last, input logic kept);
        if (kept) begin
            exp_data.push_back(word);
            exp_last.push_back(last);
        end
    endtask

    task automatic send_frame(input logic [11:0] ch, input int len, input logic kept);
        logic [63:0] word;
        word = make_header(ch, 12'(len));
        expect_word(word, 1'b0, kept);
        send_word(word);
        for (int i = 0; i < len; i++) begin
            word = make_payload();
            expect_word(word, 1'b0, kept);
            send_word(word);
        end
        word = make_footer(16'(len + 2));
        expect_word(word, 1'b1, kept);
        send_word(word);
    endtask

    task automatic wait_drain();
        @(negedge ACLK);
        while (exp_data.size() != 0 || m_valid) begin
            @(negedge ACLK);
        end
        @(posedge ACLK);
    endtask

    task automatic check_flag(input logic ok, input string what);
        assert (ok) else begin
            ctrl_errors++;
            $display("FAILED %0t: %s", $time, what);
        end
    endtask

    task automatic check_reset();
        repeat (4) @(posedge ACLK);
        rst <= 1'b0;
        check_flag(!s_tready && !m_valid && !frame_error, "outputs not low during reset");
        @(posedge ACLK);
        check_flag(!s_tready, "s_tready high in the first cycle after reset");
        @(posedge ACLK);
        check_flag(s_tready, "s_tready still low one cycle after reset");
    endtask

    task automatic test_single_frame();
        send_frame(12'h101, 5, 1'b1);
        stop_input();
        wait_drain();
    endtask

    task automatic test_back_to_back();
        int lens [8];
        lens = '{0, 3, 14, 7, 1, 10, 5, 12};
        for (int i = 0; i < 8; i++) begin
            send_frame(12'h200 + 12'(i), lens[i], 1'b1);
        end
        stop_input();
        wait_drain();
    endtask

    task automatic test_full_ring();
        int lens [5];
        lens = '{4, 9, 14, 2, 6};
        ready_mode <= RDY_LOW;
        repeat (2) @(posedge ACLK);
        for (int i = 0; i < 4; i++) begin
            send_frame(12'h300 + 12'(i), lens[i], 1'b1);
        end
        // fifth header waits in front of the full ring
        s_data <= make_header(12'h304, 12'(lens[4]));
        s_valid <= 1'b1;
        repeat (8) begin
            @(posedge ACLK);
            check_flag(!s_tready, "s_tready high while all slots are full");
        end
        ready_mode <= RDY_HIGH;
        send_frame(12'h304, lens[4], 1'b1);
        stop_input();
        wait_drain();
    endtask

    task automatic test_random_ready();
        int rnd;
        ready_mode <= RDY_RAND;
        for (int i = 0; i < 6; i++) begin
            rnd = $random(seed);
            send_frame(12'h400 + 12'(i), (rnd & 32'h7fff_ffff) % 15, 1'b1);
        end
        stop_input();
        wait_drain();
        ready_mode <= RDY_HIGH;
    endtask

    task automatic test_no_header();
        send_word(64'h1234_5678_9abc_def0);
        // stray footer outside any frame
        send_word(make_footer(16'h0007));
        send_word(make_payload());
        stop_input();
        repeat (12) @(posedge ACLK);
        send_frame(12'h500, 6, 1'b1);
        stop_input();
        wait_drain();
    endtask

    task automatic test_oversize();
        check_flag(!frame_error, "frame_error set before any oversize frame");
        send_frame(12'h600, 15, 1'b0);
        stop_input();
        @(posedge ACLK);
        check_flag(frame_error, "frame_error low after an oversize frame");
        send_frame(12'h601, 8, 1'b1);
        stop_input();
        wait_drain();
        check_flag(frame_error, "frame_error did not stay set");
    endtask

    initial begin
        int total;
        rst = 1'b1;
        s_data = '0;
        s_valid = 1'b0;
        check_reset();
        test_single_frame();
        test_back_to_back();
        test_full_ring();
        test_random_ready();
        test_no_header();
        test_oversize();
        total = data_errors + keep_errors + last_errors + hold_errors + extra_errors + ctrl_errors;
        print_counts();
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* project.f */
fbuf_pkg.sv
frame_header_decode.sv
slot_ring_ctrl.sv
frame_slot_mem.sv
frame_egress.sv
frame_buffer_top.sv
tb_frame_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile the frame buffer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_frame_buffer -Mdir obj_dir -f project.f \
    && ./obj_dir/Vtb_frame_buffer | tee /dev/stderr | grep -x "sim passed" > /dev/null \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }
